/* src/tetris_pkg.sv */
package tetris_pkg;

    // Cell color, zero is an empty cell
    typedef logic [2:0] cell_t;

    // Make codes of the game keys (A, D, space)
    localparam logic [7:0] KEY_LEFT  = 8'h1C;
    localparam logic [7:0] KEY_RIGHT = 8'h23;
    localparam logic [7:0] KEY_DROP  = 8'h29;

    // Prefix byte of a key release
    localparam logic [7:0] KEY_BREAK = 8'hF0;

    // Owner of the playfield port in the current cycle
    typedef enum logic [1:0] {
        CLIENT_NONE,
        CLIENT_CLEAR,
        CLIENT_PIECE,
        CLIENT_QUERY
    } client_t;

endpackage

/* src/key_pulse.sv */
`timescale 1ns/1ns

module key_pulse #(
    parameter logic [7:0] SCAN_CODE = tetris_pkg::KEY_LEFT
) (
    input  logic       CLK100MHZ,
    input  logic       rst,
    input  logic [7:0] scan_code,
    input  logic       scan_strobe,
    output logic       key
);

    // Set by F0, so the next byte is a release
    logic after_break;

    always_ff @(posedge CLK100MHZ) begin
        if (rst) begin
            key         <= 1'b0;
            after_break <= 1'b0;
        end else begin
            key <= 1'b0;
            if (scan_strobe) begin
                if (scan_code == tetris_pkg::KEY_BREAK) begin
                    after_break <= 1'b1;
                end else begin
                    after_break <= 1'b0;
                    if (!after_break && scan_code == SCAN_CODE) begin
                        key <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* src/field_arbiter.sv */
`timescale 1ns/1ns

module field_arbiter #(
    parameter int FIELD_W = 10,
    parameter int FIELD_H = 20
) (
    input  logic                       CLK100MHZ,
    input  logic                       rst,
    input  logic                       clear_req,
    input  logic                       clear_we,
    input  logic [$clog2(FIELD_W)-1:0] clear_x,
    input  logic [$clog2(FIELD_H)-1:0] clear_y,
    input  tetris_pkg::cell_t          clear_wdata,
    input  logic                       piece_req,
    input  logic                       piece_we,
    input  logic [$clog2(FIELD_W)-1:0] piece_x,
    input  logic [$clog2(FIELD_H)-1:0] piece_y,
    input  tetris_pkg::cell_t          piece_wdata,
    input  logic                       query_req,
    input  logic [$clog2(FIELD_W)-1:0] query_x,
    input  logic [$clog2(FIELD_H)-1:0] query_y,
    output logic                       clear_gnt,
    output logic                       piece_gnt,
    output logic                       query_gnt,
    output tetris_pkg::cell_t          rdata,
    output logic                       init_busy
);

    localparam int XW    = $clog2(FIELD_W);
    localparam int YW    = $clog2(FIELD_H);
    localparam int CELLS = FIELD_W * FIELD_H;
    localparam int AW    = $clog2(CELLS);

    tetris_pkg::cell_t   mem [CELLS];
    logic [AW-1:0]       init_addr;
    tetris_pkg::client_t grant;
    tetris_pkg::client_t last_grant;
    logic [XW-1:0]       acc_x;
    logic [YW-1:0]       acc_y;
    logic                acc_we;
    tetris_pkg::cell_t   acc_wdata;
    logic [AW-1:0]       acc_addr;

    // Fixed priority where the previous owner sits out one cycle
    always_comb begin
        grant = tetris_pkg::CLIENT_NONE;
        if (!init_busy) begin
            if (clear_req && last_grant != tetris_pkg::CLIENT_CLEAR) begin
                grant = tetris_pkg::CLIENT_CLEAR;
            end else if (piece_req && last_grant != tetris_pkg::CLIENT_PIECE) begin
                grant = tetris_pkg::CLIENT_PIECE;
            end else if (query_req && last_grant != tetris_pkg::CLIENT_QUERY) begin
                grant = tetris_pkg::CLIENT_QUERY;
            end
        end
    end

    assign clear_gnt = (grant == tetris_pkg::CLIENT_CLEAR);
    assign piece_gnt = (grant == tetris_pkg::CLIENT_PIECE);
    assign query_gnt = (grant == tetris_pkg::CLIENT_QUERY);

    always_comb begin
        case (grant)
            tetris_pkg::CLIENT_CLEAR: begin
                acc_x     = clear_x;
                acc_y     = clear_y;
                acc_we    = clear_we;
                acc_wdata = clear_wdata;
            end
            tetris_pkg::CLIENT_PIECE: begin
                acc_x     = piece_x;
                acc_y     = piece_y;
                acc_we    = piece_we;
                acc_wdata = piece_wdata;
            end
            default: begin
                acc_x     = query_x;
                acc_y     = query_y;
                acc_we    = 1'b0;
                acc_wdata = '0;
            end
        endcase
    end

    assign acc_addr = AW'(acc_y) * AW'(FIELD_W) + AW'(acc_x);

    // Field wipe after reset at one cell per cycle
    always_ff @(posedge CLK100MHZ) begin
        if (rst) begin
            init_busy  <= 1'b1;
            init_addr  <= '0;
            last_grant <= tetris_pkg::CLIENT_NONE;
        end else begin
            last_grant <= grant;
            if (init_busy) begin
                init_addr <= init_addr + 1'b1;
                if (init_addr == AW'(CELLS - 1)) begin
                    init_busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (init_busy) begin
            mem[init_addr] <= '0;
        end else if (grant != tetris_pkg::CLIENT_NONE && acc_we) begin
            mem[acc_addr] <= acc_wdata;
        end
        rdata <= mem[acc_addr];
    end

    a_one_grant: assert property (@(posedge CLK100MHZ) disable iff (rst)
        $onehot0({clear_gnt, piece_gnt, query_gnt}));

    // A client keeps its request up until it is granted
    a_req_held: assert property (@(posedge CLK100MHZ) disable iff (rst)
        ($past({clear_req, piece_req, query_req} & ~{clear_gnt, piece_gnt, query_gnt})
         & ~{clear_req, piece_req, query_req}) == 3'b000);

endmodule

/* src/piece_control.sv */
`timescale 1ns/1ns

module piece_control #(
    parameter int FIELD_W  = 10,
    parameter int FIELD_H  = 20,
    parameter int TICK_DIV = 1666666
) (
    input  logic                       CLK100MHZ,
    input  logic                       rst,
    input  logic                       key_left,
    input  logic                       key_right,
    input  logic                       key_drop,
    input  logic                       clear_busy,
    input  logic                       init_busy,
    input  logic                       piece_gnt,
    input  tetris_pkg::cell_t          rdata,
    output logic                       piece_req,
    output logic                       piece_we,
    output logic [$clog2(FIELD_W)-1:0] piece_x,
    output logic [$clog2(FIELD_H)-1:0] piece_y,
    output tetris_pkg::cell_t          piece_wdata,
    output logic                       lock_done,
    output logic [$clog2(FIELD_W)-1:0] piece_col,
    output logic [$clog2(FIELD_H)-1:0] piece_row,
    output tetris_pkg::cell_t          piece_color,
    output logic                       game_over
);

    localparam int XW = $clog2(FIELD_W);
    localparam int YW = $clog2(FIELD_H);
    localparam int TW = $clog2(TICK_DIV);

    typedef enum logic [2:0] {
        P_SPAWN,
        P_IDLE,
        P_CHECK,
        P_LOCK,
        P_OVER
    } piece_state_t;

    piece_state_t  state;
    logic [TW-1:0] tick_cnt;
    logic          tick;
    logic          pend;
    logic          dropping;
    logic          start_ok;
    logic [XW-1:0] tgt_col;
    logic [YW-1:0] tgt_row;

    // Gravity tick
    assign tick = (tick_cnt == TW'(TICK_DIV - 1));

    always_ff @(posedge CLK100MHZ) begin
        if (rst || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Wait out the field wipe and any row clearing
    assign start_ok = !init_busy && !clear_busy && !lock_done;

    assign piece_x     = (state == P_CHECK) ? tgt_col : piece_col;
    assign piece_y     = (state == P_CHECK) ? tgt_row : piece_row;
    assign piece_we    = (state == P_LOCK);
    assign piece_wdata = piece_color;

    always_ff @(posedge CLK100MHZ) begin
        if (rst) begin
            state       <= P_SPAWN;
            piece_req   <= 1'b0;
            pend        <= 1'b0;
            dropping    <= 1'b0;
            lock_done   <= 1'b0;
            game_over   <= 1'b0;
            piece_col   <= XW'(FIELD_W / 2);
            piece_row   <= '0;
            piece_color <= 3'd1;
        end else begin
            lock_done <= 1'b0;
            case (state)
                P_SPAWN: begin
                    if (pend) begin
                        pend <= 1'b0;
                        if (rdata != '0) begin
                            game_over <= 1'b1;
                            state     <= P_OVER;
                        end else begin
                            state <= P_IDLE;
                        end
                    end else if (piece_gnt) begin
                        piece_req <= 1'b0;
                        pend      <= 1'b1;
                    end else if (start_ok) begin
                        piece_req <= 1'b1;
                    end
                end
                P_IDLE: begin
                    if (tick || key_drop || dropping) begin
                        dropping <= dropping | key_drop;
                        tgt_col  <= piece_col;
                        if (piece_row == YW'(FIELD_H - 1)) begin
                            dropping <= 1'b0;
                            state    <= P_LOCK;
                        end else begin
                            tgt_row <= piece_row + 1'b1;
                            state   <= P_CHECK;
                        end
                    end else if (key_left && piece_col != '0) begin
                        tgt_col <= piece_col - 1'b1;
                        tgt_row <= piece_row;
                        state   <= P_CHECK;
                    end else if (key_right && piece_col != XW'(FIELD_W - 1)) begin
                        tgt_col <= piece_col + 1'b1;
                        tgt_row <= piece_row;
                        state   <= P_CHECK;
                    end
                end
                P_CHECK: begin
                    if (pend) begin
                        pend <= 1'b0;
                        if (tgt_row != piece_row) begin
                            // Step down, or land on the cell below
                            if (rdata == '0) begin
                                piece_row <= tgt_row;
                                state     <= P_IDLE;
                            end else begin
                                dropping <= 1'b0;
                                state    <= P_LOCK;
                            end
                        end else begin
                            if (rdata == '0) begin
                                piece_col <= tgt_col;
                            end
                            state <= P_IDLE;
                        end
                    end else if (piece_gnt) begin
                        piece_req <= 1'b0;
                        pend      <= 1'b1;
                    end else begin
                        piece_req <= 1'b1;
                    end
                end
                P_LOCK: begin
                    if (piece_gnt) begin
                        piece_req   <= 1'b0;
                        lock_done   <= 1'b1;
                        piece_col   <= XW'(FIELD_W / 2);
                        piece_row   <= '0;
                        piece_color <= (piece_color == 3'd7) ? 3'd1 : piece_color + 3'd1;
                        state       <= P_SPAWN;
                    end else begin
                        piece_req <= 1'b1;
                    end
                end
                default: begin
                    // Game over holds until reset
                end
            endcase
        end
    end

    a_piece_in_field: assert property (@(posedge CLK100MHZ) disable iff (rst)
        piece_col < FIELD_W && piece_row < FIELD_H);

endmodule

/* src/row_clear.sv */
`timescale 1ns/1ns

module row_clear #(
    parameter int FIELD_W = 10,
    parameter int FIELD_H = 20
) (
    input  logic                       CLK100MHZ,
    input  logic                       rst,
    input  logic                       lock_done,
    input  logic                       clear_gnt,
    input  tetris_pkg::cell_t          rdata,
    output logic                       clear_req,
    output logic                       clear_we,
    output logic [$clog2(FIELD_W)-1:0] clear_x,
    output logic [$clog2(FIELD_H)-1:0] clear_y,
    output tetris_pkg::cell_t          clear_wdata,
    output logic                       clear_busy,
    output logic [15:0]                score
);

    localparam int XW = $clog2(FIELD_W);
    localparam int YW = $clog2(FIELD_H);

    typedef enum logic [2:0] {
        CL_IDLE,
        CL_SCAN,
        CL_READ,
        CL_WRITE,
        CL_ZERO
    } clear_state_t;

    clear_state_t      state;
    logic              pend;
    logic [XW-1:0]     col;
    logic [YW-1:0]     row;
    logic [YW-1:0]     dst;
    tetris_pkg::cell_t wbuf;
    logic [15:0]       cleared;
    logic              last_col;

    assign last_col = (col == XW'(FIELD_W - 1));

    // Cell addressed by the current step
    always_comb begin
        clear_x = col;
        case (state)
            CL_SCAN:  clear_y = row;
            CL_READ:  clear_y = dst - 1'b1;
            CL_WRITE: clear_y = dst;
            default:  clear_y = '0;
        endcase
    end

    assign clear_we    = (state == CL_WRITE) || (state == CL_ZERO);
    assign clear_wdata = (state == CL_WRITE) ? wbuf : '0;

    always_ff @(posedge CLK100MHZ) begin
        if (rst) begin
            state      <= CL_IDLE;
            clear_req  <= 1'b0;
            pend       <= 1'b0;
            clear_busy <= 1'b0;
            score      <= '0;
        end else begin
            case (state)
                CL_IDLE: begin
                    if (lock_done) begin
                        clear_busy <= 1'b1;
                        clear_req  <= 1'b1;
                        row        <= YW'(FIELD_H - 1);
                        col        <= '0;
                        cleared    <= '0;
                        state      <= CL_SCAN;
                    end
                end
                CL_SCAN: begin
                    if (pend) begin
                        pend      <= 1'b0;
                        clear_req <= 1'b1;
                        if (rdata == '0) begin
                            // Row has a hole, go one row up
                            col <= '0;
                            if (row == '0) begin
                                clear_req  <= 1'b0;
                                clear_busy <= 1'b0;
                                score      <= score + cleared;
                                state      <= CL_IDLE;
                            end else begin
                                row <= row - 1'b1;
                            end
                        end else if (last_col) begin
                            col     <= '0;
                            cleared <= cleared + 1'b1;
                            dst     <= row;
                            state   <= (row == '0) ? CL_ZERO : CL_READ;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end else if (clear_gnt) begin
                        clear_req <= 1'b0;
                        pend      <= 1'b1;
                    end else begin
                        clear_req <= 1'b1;
                    end
                end
                CL_READ: begin
                    if (pend) begin
                        pend      <= 1'b0;
                        clear_req <= 1'b1;
                        wbuf      <= rdata;
                        state     <= CL_WRITE;
                    end else if (clear_gnt) begin
                        clear_req <= 1'b0;
                        pend      <= 1'b1;
                    end else begin
                        clear_req <= 1'b1;
                    end
                end
                CL_WRITE: begin
                    if (clear_gnt) begin
                        clear_req <= 1'b0;
                        state     <= CL_READ;
                        if (last_col) begin
                            col <= '0;
                            dst <= dst - 1'b1;
                            if (dst == YW'(1)) begin
                                state <= CL_ZERO;
                            end
                        end else begin
                            col <= col + 1'b1;
                        end
                    end else begin
                        clear_req <= 1'b1;
                    end
                end
                default: begin
                    // Empty top row, then rescan the same row
                    if (clear_gnt) begin
                        clear_req <= 1'b0;
                        if (last_col) begin
                            col   <= '0;
                            state <= CL_SCAN;
                        end else begin
                            col <= col + 1'b1;
                        end
                    end else begin
                        clear_req <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* src/tetris_field_top.sv */
`timescale 1ns/1ns

module tetris_field_top #(
    parameter int FIELD_W  = 10,
    parameter int FIELD_H  = 20,
    parameter int TICK_DIV = 1666666
) (
    input  logic                       CLK100MHZ,
    input  logic                       rst,
    input  logic [7:0]                 scan_code,
    input  logic                       scan_strobe,
    input  logic                       query_strobe,
    input  logic [$clog2(FIELD_W)-1:0] query_x,
    input  logic [$clog2(FIELD_H)-1:0] query_y,
    output logic                       query_ready,
    output tetris_pkg::cell_t          query_color,
    output logic [$clog2(FIELD_W)-1:0] piece_col,
    output logic [$clog2(FIELD_H)-1:0] piece_row,
    output tetris_pkg::cell_t          piece_color,
    output logic [15:0]                score,
    output logic                       game_over
);

    localparam int XW = $clog2(FIELD_W);
    localparam int YW = $clog2(FIELD_H);

    logic key_left;
    logic key_right;
    logic key_drop;

    logic              clear_req, clear_we, clear_gnt;
    logic [XW-1:0]     clear_x;
    logic [YW-1:0]     clear_y;
    tetris_pkg::cell_t clear_wdata;
    logic              piece_req, piece_we, piece_gnt;
    logic [XW-1:0]     piece_x;
    logic [YW-1:0]     piece_y;
    tetris_pkg::cell_t piece_wdata;
    logic              query_req, query_gnt;
    logic [XW-1:0]     q_x;
    logic [YW-1:0]     q_y;
    tetris_pkg::cell_t rdata;
    tetris_pkg::cell_t color_hold;
    logic              init_busy;
    logic              lock_done;
    logic              clear_busy;

    key_pulse #(.SCAN_CODE(tetris_pkg::KEY_LEFT)) k_left (
        .CLK100MHZ(CLK100MHZ), .rst(rst), .scan_code(scan_code),
        .scan_strobe(scan_strobe), .key(key_left)
    );
    key_pulse #(.SCAN_CODE(tetris_pkg::KEY_RIGHT)) k_right (
        .CLK100MHZ(CLK100MHZ), .rst(rst), .scan_code(scan_code),
        .scan_strobe(scan_strobe), .key(key_right)
    );
    key_pulse #(.SCAN_CODE(tetris_pkg::KEY_DROP)) k_drop (
        .CLK100MHZ(CLK100MHZ), .rst(rst), .scan_code(scan_code),
        .scan_strobe(scan_strobe), .key(key_drop)
    );

    piece_control #(.FIELD_W(FIELD_W), .FIELD_H(FIELD_H), .TICK_DIV(TICK_DIV)) u_piece (
        .CLK100MHZ(CLK100MHZ), .rst(rst),
        .key_left(key_left), .key_right(key_right), .key_drop(key_drop),
        .clear_busy(clear_busy), .init_busy(init_busy),
        .piece_gnt(piece_gnt), .rdata(rdata),
        .piece_req(piece_req), .piece_we(piece_we), .piece_x(piece_x),
        .piece_y(piece_y), .piece_wdata(piece_wdata), .lock_done(lock_done),
        .piece_col(piece_col), .piece_row(piece_row), .piece_color(piece_color),
        .game_over(game_over)
    );

    row_clear #(.FIELD_W(FIELD_W), .FIELD_H(FIELD_H)) u_clear (
        .CLK100MHZ(CLK100MHZ), .rst(rst), .lock_done(lock_done),
        .clear_gnt(clear_gnt), .rdata(rdata),
        .clear_req(clear_req), .clear_we(clear_we), .clear_x(clear_x),
        .clear_y(clear_y), .clear_wdata(clear_wdata),
        .clear_busy(clear_busy), .score(score)
    );

    field_arbiter #(.FIELD_W(FIELD_W), .FIELD_H(FIELD_H)) u_field (
        .CLK100MHZ(CLK100MHZ), .rst(rst),
        .clear_req(clear_req), .clear_we(clear_we), .clear_x(clear_x),
        .clear_y(clear_y), .clear_wdata(clear_wdata),
        .piece_req(piece_req), .piece_we(piece_we), .piece_x(piece_x),
        .piece_y(piece_y), .piece_wdata(piece_wdata),
        .query_req(query_req), .query_x(q_x), .query_y(q_y),
        .clear_gnt(clear_gnt), .piece_gnt(piece_gnt), .query_gnt(query_gnt),
        .rdata(rdata), .init_busy(init_busy)
    );

    // Display query, held until the arbiter takes it
    always_ff @(posedge CLK100MHZ) begin
        if (rst) begin
            query_req   <= 1'b0;
            query_ready <= 1'b0;
        end else begin
            query_ready <= query_gnt;
            if (query_strobe) begin
                query_req <= 1'b1;
            end else if (query_gnt) begin
                query_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (query_strobe) begin
            q_x <= query_x;
            q_y <= query_y;
        end
        if (query_ready) begin
            color_hold <= rdata;
        end
    end

    // Last answer stays visible after the ready pulse
    assign query_color = query_ready ? rdata : color_hold;

endmodule

/* tests/tetris_field_tb.sv */
`timescale 1ns/1ns

module tetris_field_tb;

    localparam int FIELD_W       = 6;
    localparam int FIELD_H       = 8;
    localparam int TICK_DIV      = 4000;
    localparam int XW            = $clog2(FIELD_W);
    localparam int YW            = $clog2(FIELD_H);
    localparam int TRACE_LEN     = 256;
    localparam int QUERY_TIMEOUT = 1000;
    localparam int RESET_CYCLES  = 16;

    // Trace word fields are op[31:28], a[27:20], b[19:16], value[15:0]
    localparam logic [3:0] OP_TEST  = 4'h0;
    localparam logic [3:0] OP_KEY   = 4'h1;
    localparam logic [3:0] OP_WAIT  = 4'h2;
    localparam logic [3:0] OP_PIECE = 4'h3;
    localparam logic [3:0] OP_QUERY = 4'h4;
    localparam logic [3:0] OP_SCORE = 4'h5;
    localparam logic [3:0] OP_OVER  = 4'h6;
    localparam logic [3:0] OP_END   = 4'hF;

    logic              CLK100MHZ;
    logic              rst;
    logic [7:0]        scan_code;
    logic              scan_strobe;
    logic              query_strobe;
    logic [XW-1:0]     query_x;
    logic [YW-1:0]     query_y;
    logic              query_ready;
    tetris_pkg::cell_t query_color;
    logic [XW-1:0]     piece_col;
    logic [YW-1:0]     piece_row;
    tetris_pkg::cell_t piece_color;
    logic [15:0]       score;
    logic              game_over;

    logic [31:0] trace_mem [TRACE_LEN];
    int          trace_count;
    int          wait_total;
    logic        trace_loaded;
    int          errors;
    int          checks;
    string       test_name;

    tetris_field_top #(
        .FIELD_W(FIELD_W),
        .FIELD_H(FIELD_H),
        .TICK_DIV(TICK_DIV)
    ) uut (
        .CLK100MHZ(CLK100MHZ),
        .rst(rst),
        .scan_code(scan_code),
        .scan_strobe(scan_strobe),
        .query_strobe(query_strobe),
        .query_x(query_x),
        .query_y(query_y),
        .query_ready(query_ready),
        .query_color(query_color),
        .piece_col(piece_col),
        .piece_row(piece_row),
        .piece_color(piece_color),
        .score(score),
        .game_over(game_over)
    );

    initial begin
        CLK100MHZ = 1'b0;
        forever #5 CLK100MHZ = ~CLK100MHZ;
    end

    function automatic string name_of_test(input int id);
        case (id)
            1: return "reset_state";
            2: return "moves";
            3: return "gravity_drop";
            4: return "row_clear";
            5: return "game_over";
            default: return $sformatf("test_%0d", id);
        endcase
    endfunction

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("** Error %s %s: expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(posedge CLK100MHZ);
            #1;
        end
    endtask

    // One scan byte with its strobe for a single cycle
    task automatic send_byte(input logic [7:0] code);
        scan_code   = code;
        scan_strobe = 1'b1;
        @(posedge CLK100MHZ);
        #1;
        scan_strobe = 1'b0;
    endtask

    task automatic query_cell(input int x, input int y, input int expected);
        int waited;
        waited       = 0;
        query_x      = x[XW-1:0];
        query_y      = y[YW-1:0];
        query_strobe = 1'b1;
        @(posedge CLK100MHZ);
        #1;
        query_strobe = 1'b0;
        while (!query_ready && waited < QUERY_TIMEOUT) begin
            @(posedge CLK100MHZ);
            #1;
            waited++;
        end
        checks++;
        assert (query_ready) else begin
            errors++;
            $display("%s: query of cell (%0d,%0d) got no answer within %0d cycles",
                     test_name, x, y, QUERY_TIMEOUT);
        end
        if (query_ready) begin
            check_value($sformatf("cell (%0d,%0d)", x, y), expected, int'(query_color));
        end
    endtask

    // Loads the trace and sums its waits for the watchdog
    task automatic load_trace();
        logic [3:0] op;
        trace_count = 0;
        wait_total  = 0;
        $readmemh("tests/tetris_field_trace.txt", trace_mem);
        for (int i = 0; i < TRACE_LEN; i++) begin
            op = trace_mem[i][31:28];
            if (op == OP_END) begin
                trace_count = i;
                break;
            end
            if (op == OP_KEY || op == OP_WAIT) begin
                wait_total += int'(trace_mem[i][15:0]);
            end
        end
        if (trace_count == 0) begin
            errors++;
            $display("Trace file is empty or has no end marker");
        end
    endtask

    task automatic run_trace();
        logic [31:0] word;
        logic [3:0]  op;
        int          a;
        int          b;
        int          value;
        for (int i = 0; i < trace_count; i++) begin
            word  = trace_mem[i];
            op    = word[31:28];
            a     = int'(word[27:20]);
            b     = int'(word[19:16]);
            value = int'(word[15:0]);
            case (op)
                OP_TEST: test_name = name_of_test(value);
                OP_KEY: begin
                    send_byte(word[27:20]);
                    run_cycles(value);
                end
                OP_WAIT: run_cycles(value);
                OP_PIECE: begin
                    check_value("piece_col", a, int'(piece_col));
                    check_value("piece_row", b, int'(piece_row));
                    check_value("piece_color", value, int'(piece_color));
                end
                OP_QUERY: query_cell(a, b, value);
                OP_SCORE: check_value("score", value, int'(score));
                OP_OVER: check_value("game_over", value, int'(game_over));
                default: begin
                    errors++;
                    $display("Trace entry %0d has an unknown op %h", i, op);
                end
            endcase
        end
    endtask

    initial begin
        rst          = 1'b1;
        scan_code    = '0;
        scan_strobe  = 1'b0;
        query_strobe = 1'b0;
        query_x      = '0;
        query_y      = '0;
        errors       = 0;
        checks       = 0;
        test_name    = "setup";
        trace_loaded = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK100MHZ);
        #1;
        rst = 1'b0;
        run_trace();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Limit is the trace's total wait plus a margin for queries
    initial begin
        wait (trace_loaded);
        repeat (RESET_CYCLES + wait_total + 10000) @(posedge CLK100MHZ);
        $display("Watchdog stopped the run after %0d cycles, the trace did not finish",
                 RESET_CYCLES + wait_total + 10000);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* tests/tetris_field_trace.txt */
// One word per line, op_a_b_value in hex. op 0 test id, 1 key byte a then wait value,
// 2 wait value, 3 piece col a row b color value, 4 query (a,b) expects value,
// 5 score, 6 game over, f end of trace
0_00_0_0001
2_00_0_0064
3_03_0_0001
6_00_0_0000
5_00_0_0000
4_00_0_0000
4_05_7_0000
0_00_0_0002
1_1c_0_000a
3_02_0_0001
1_1c_0_000a
1_1c_0_000a
3_00_0_0001
// Left key at the wall
1_1c_0_000a
3_00_0_0001
// Release of D
1_f0_0_0000
1_23_0_000a
3_00_0_0001
1_23_0_000a
3_01_0_0001
0_00_0_0003
// First gravity tick at cycle 4000
2_00_0_0f09
3_01_1_0001
1_29_0_00c8
3_03_0_0002
4_01_7_0001
0_00_0_0004
1_29_0_00c8
4_03_7_0002
1_1c_0_000a
1_1c_0_000a
1_1c_0_000a
3_00_0_0003
1_29_0_00c8
1_1c_0_000a
1_29_0_00c8
// Color 5 lands on top of color 2
1_29_0_00c8
4_03_6_0005
3_03_0_0006
1_23_0_000a
1_29_0_00c8
1_23_0_000a
1_23_0_000a
3_05_0_0007
// Completes the bottom row
1_29_0_0258
5_00_0_0001
3_03_0_0001
4_03_7_0005
4_03_6_0000
4_00_7_0000
0_00_0_0005
// Past the second tick at cycle 8000
2_00_0_083a
3_03_1_0001
1_29_0_0096
1_29_0_0096
1_29_0_0096
1_29_0_0096
1_29_0_0096
1_29_0_0096
6_00_0_0000
1_29_0_0096
6_00_0_0001
1_1c_0_000a
1_29_0_0032
3_03_0_0001
6_00_0_0001
4_03_0_0007
4_03_7_0005
5_00_0_0001
f_00_0_0000

/* project.f */
src/tetris_pkg.sv
src/key_pulse.sv
src/field_arbiter.sv
src/piece_control.sv
src/row_clear.sv
src/tetris_field_top.sv
tests/tetris_field_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tetris_field_tb -o tetris_field_sim -f project.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tetris_field_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
